// ==== files.f ====
lcd_pkg.sv
lcd_init_rom.sv
lcd_wait_timer.sv
lcd_sequencer.sv
serial_byte_master.sv
text_buffer.sv
txtlcd_top.sv
tb_txtlcd_sva.sv
tb_txtlcd.sv

// ==== tb_txtlcd.sv ====
// testbench of the 4x20 character lcd controller
// runs reset, init with busy polling and two display updates on the top
// level; a display model on the serial pins decodes every byte, answers
// status reads and queues all other bytes for the test tasks

`timescale 1ns/1ns
`default_nettype none

module tb_txtlcd import lcd_pkg::*; ();

	localparam int ticks_per_100us = 2;
	localparam int sclk_div        = 2;
	localparam int use_busy_flag   = 1;

	// run budget from all delays, init bytes with worst polling and two updates
	localparam int byte_cycles  = 16 * sclk_div + 4;
	localparam int init_bytes   = 3 * init_num_commands + 2 * 4 * init_num_commands;
	localparam int update_bytes = 2 * lcd_size + 4;
	localparam int delay_cycles = ticks_per_100us * (delay_prereset + delay_reset
		+ delay_settle + 3 * delay_update + 2 * delay_cmd);
	localparam int cycle_limit  = delay_cycles
		+ (init_bytes + 2 * update_bytes) * byte_cycles + 4 * lcd_size + 5000;

	logic                     in_clk;
	logic                     in_rst;
	logic                     update;
	logic                     update_ready;
	logic                     buf_wr_en;
	logic [lcd_addr_bits-1:0] buf_wr_addr;
	logic [7:0]               buf_wr_char;
	logic                     lcd_rst_n;
	logic                     lcd_cs_n;
	logic                     lcd_sclk;
	logic                     lcd_sdi;
	logic                     lcd_sdo;
	logic [7:0]               busy_status;

	int seed = 32'h01c17ca6;
	int checks = 0;
	int errors = 0;
	int cycles = 0;

	// expected init table and host copy of the text buffer
	init_cmd_t  init_tab [init_num_commands];
	logic [7:0] shadow [lcd_size];

	// display model state
	lcd_serial_byte_u rx_q[$];
	int               busy_q[$];
	int               poll_q[$];
	logic [7:0]       in_sh = '0;
	logic [7:0]       resp_sh = '0;
	logic [7:0]       last_status = '0;
	int               bit_n = 0;
	int               nib_n = 0;
	int               cmd_seen = 0;
	int               busy_left = 0;
	bit               expect_dummy = 1'b0;
	bit               need_poll = 1'b0;

	txtlcd_top #(
		.ticks_per_100us(ticks_per_100us),
		.sclk_div(sclk_div),
		.use_busy_flag(use_busy_flag)
	) i_txtlcd_top (
		.in_clk, .in_rst, .update, .update_ready, .buf_wr_en, .buf_wr_addr,
		.buf_wr_char, .lcd_rst_n, .lcd_cs_n, .lcd_sclk, .lcd_sdi, .lcd_sdo, .busy_status
	);

	initial begin
		in_clk = 1'b0;
		forever #5 in_clk = ~in_clk;
	end

	initial begin
		init_tab = '{
			'{ctrl_command, 8'h3B}, '{ctrl_command, 8'h02}, '{ctrl_command, 8'h06},
			'{ctrl_command, 8'h09}, '{ctrl_command, 8'h10}, '{ctrl_command, 8'hC0},
			'{ctrl_command, 8'h72}, '{ctrl_data, 8'h00},    '{ctrl_command, 8'h76},
			'{ctrl_data, 8'h02},    '{ctrl_command, 8'h3A}, '{ctrl_command, 8'h12},
			'{ctrl_command, 8'h39}, '{ctrl_command, 8'h1B}, '{ctrl_command, 8'h57},
			'{ctrl_command, 8'h70}, '{ctrl_command, 8'h6E}, '{ctrl_command, 8'h38},
			'{ctrl_command, 8'h06}, '{ctrl_command, 8'h0C}, '{ctrl_command, 8'h01},
			'{ctrl_command, 8'h02}
		};
	end

	// -------------------------------------------------------------------
	// reporting and compare tasks
	// -------------------------------------------------------------------
	task automatic report_error(input string what);
		errors++;
		$display("error at %0t ns: %s", $time, what);
	endtask

	task automatic check_byte(input string name, input lcd_serial_byte_u got,
			input lcd_serial_byte_u exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %0t ns %s: got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_status(input string name, input logic [7:0] got,
			input logic [7:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %0t ns %s: got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_pin(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %0t ns %s: got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		checks++;
		if (got != exp) begin
			errors++;
			$display("[FAIL] %0t ns %s: got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	// expected bus bytes
	function automatic lcd_serial_byte_u ctrl_byte(input logic [3:0] code);
		lcd_serial_byte_u b;
		b.ctrl_view.code = code;
		b.ctrl_view.ones = 4'hF;
		return b;
	endfunction

	function automatic lcd_serial_byte_u nibble_byte(input logic [3:0] n);
		lcd_serial_byte_u b;
		b.data_view.zero   = 4'h0;
		b.data_view.nibble = n;
		return b;
	endfunction

	// -------------------------------------------------------------------
	// display model
	// -------------------------------------------------------------------
	task automatic take_byte(input lcd_serial_byte_u b);
		logic [7:0] status;
		if (expect_dummy) begin
			// status went out during this byte
			expect_dummy = 1'b0;
		end else if (b.data_view.zero != 4'h0) begin
			if (b.ctrl_view.ones != 4'hF)
				report_error("control byte with a low nibble other than all ones");
			if (b.ctrl_view.code == ctrl_read) begin
				if (!need_poll)
					report_error("status read without a pending command");
				// every read counts against the latest command
				if (poll_q.size() != 0)
					poll_q[poll_q.size() - 1] = poll_q[poll_q.size() - 1] + 1;
				status[6:0]      = 7'($random(seed));
				status[busy_bit] = (busy_left != 0);
				if (busy_left != 0)
					busy_left--;
				else
					need_poll = 1'b0;
				last_status  = status;
				resp_sh      = status;
				expect_dummy = 1'b1;
			end else begin
				if (need_poll)
					report_error("command started while the display still reported busy");
				if (nib_n != 0)
					report_error("control byte in the middle of a nibble pair");
				nib_n = 0;
				rx_q.push_back(b);
			end
		end else begin
			rx_q.push_back(b);
			nib_n = 1 - nib_n;
			// a full init command makes the display busy for a while
			if (nib_n == 0 && cmd_seen < init_num_commands) begin
				cmd_seen++;
				busy_left = {$random(seed)} % 4;
				busy_q.push_back(busy_left);
				poll_q.push_back(0);
				need_poll = 1'b1;
			end
		end
	endtask

	// sdi sampled on rising sclk, sdo changes on falling sclk
	always @(posedge lcd_sclk or negedge lcd_sclk) begin
		if (lcd_cs_n === 1'b0) begin
			if (lcd_sclk) begin
				in_sh = {in_sh[6:0], lcd_sdi};
				bit_n++;
				if (bit_n == 8) begin
					bit_n = 0;
					take_byte(in_sh);
				end
			end else begin
				lcd_sdo <= resp_sh[7];
				resp_sh = {resp_sh[6:0], 1'b0};
			end
		end
	end

	// run limit
	always @(posedge in_clk) begin
		cycles++;
		if (cycles >= cycle_limit) begin
			$display("timeout: run exceeded %0d cycles, %0d errors so far", cycle_limit, errors);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	// -------------------------------------------------------------------
	// helpers
	// -------------------------------------------------------------------
	task automatic next_byte(input string what, output lcd_serial_byte_u b);
		b = '0;
		if (rx_q.size() == 0)
			report_error({"display model received no byte for ", what});
		else
			b = rx_q.pop_front();
	endtask

	task automatic expect_cmd(input string what, input init_cmd_t c);
		lcd_serial_byte_u b;
		next_byte(what, b);
		check_byte({what, " control byte"}, b, ctrl_byte(c.ctrl));
		next_byte(what, b);
		check_byte({what, " low nibble"}, b, nibble_byte(c.cmd[3:0]));
		next_byte(what, b);
		check_byte({what, " high nibble"}, b, nibble_byte(c.cmd[7:4]));
	endtask

	task automatic wait_ready();
		@(negedge in_clk);
		while (update_ready !== 1'b1)
			@(negedge in_clk);
	endtask

	task automatic write_char(input int addr, input logic [7:0] ch);
		@(posedge in_clk);
		buf_wr_en   <= 1'b1;
		buf_wr_addr <= lcd_addr_bits'(addr);
		buf_wr_char <= ch;
		shadow[addr] = ch;
	endtask

	task automatic pulse_update();
		@(posedge in_clk);
		buf_wr_en <= 1'b0;
		update    <= 1'b1;
		@(posedge in_clk);
		update <= 1'b0;
	endtask

	// home, data control byte, then low and high nibble per character
	task automatic check_update_bytes(input string what);
		lcd_serial_byte_u b;
		int               i;
		expect_cmd({what, " home"}, '{ctrl_command, 8'h02});
		next_byte(what, b);
		check_byte({what, " data control byte"}, b, ctrl_byte(ctrl_data));
		for (i = 0; i < lcd_size; i++) begin
			next_byte(what, b);
			check_byte($sformatf("%s char %0d low", what, i), b, nibble_byte(shadow[i][3:0]));
			next_byte(what, b);
			check_byte($sformatf("%s char %0d high", what, i), b, nibble_byte(shadow[i][7:4]));
		end
		check_count({what, " leftover bytes"}, rx_q.size(), 0);
	endtask

	// -------------------------------------------------------------------
	// tests
	// -------------------------------------------------------------------
	task automatic test_reset();
		int n;
		repeat (7) @(posedge in_clk);
		@(negedge in_clk);
		check_pin("lcd_cs_n", lcd_cs_n, 1'b1);
		check_pin("lcd_sclk", lcd_sclk, 1'b0);
		check_pin("update_ready", update_ready, 1'b0);
		check_pin("lcd_rst_n", lcd_rst_n, 1'b1);
		@(posedge in_clk);
		in_rst <= 1'b0;
		// first edge that sees reset released
		@(posedge in_clk);
		@(negedge in_clk);
		n = 0;
		while (lcd_rst_n === 1'b1) begin
			@(negedge in_clk);
			n++;
		end
		check_count("cycles to lcd_rst_n fall", n, delay_prereset * ticks_per_100us);
		n = 0;
		while (lcd_rst_n === 1'b0) begin
			@(negedge in_clk);
			n++;
		end
		check_count("lcd_rst_n low cycles", n, delay_reset * ticks_per_100us);
	endtask

	task automatic test_init();
		int i;
		wait_ready();
		check_count("init bytes received", rx_q.size(), 3 * init_num_commands);
		for (i = 0; i < init_num_commands; i++)
			expect_cmd($sformatf("init %0d", i), init_tab[i]);
		rx_q.delete();
	endtask

	task automatic test_busy_polling();
		int i;
		check_count("busy counts drawn", busy_q.size(), init_num_commands);
		check_count("poll sequences seen", poll_q.size(), init_num_commands);
		for (i = 0; i < init_num_commands && i < poll_q.size() && i < busy_q.size(); i++)
			check_count($sformatf("polls after init %0d", i), poll_q[i], busy_q[i] + 1);
		check_status("busy_status", busy_status, last_status);
	endtask

	task automatic test_update();
		int i;
		for (i = 0; i < lcd_size; i++)
			write_char(i, 8'($random(seed)));
		pulse_update();
		@(negedge in_clk);
		check_pin("update_ready during update", update_ready, 1'b0);
		wait_ready();
		check_update_bytes("update 1");
	endtask

	task automatic test_ignored_and_rewrite();
		int i;
		// rewrite a spread of positions
		for (i = 0; i < 20; i++)
			write_char(5 + i * 3, 8'($random(seed)));
		pulse_update();
		@(negedge in_clk);
		check_pin("update_ready during update", update_ready, 1'b0);
		repeat (300) @(negedge in_clk);
		check_pin("update_ready before extra request", update_ready, 1'b0);
		pulse_update();
		wait_ready();
		check_update_bytes("update 2");
		repeat (200) @(negedge in_clk);
		check_count("bytes after ignored request", rx_q.size(), 0);
		check_pin("lcd_cs_n when idle", lcd_cs_n, 1'b1);
	endtask

	initial begin
		in_rst      <= 1'b1;
		update      <= 1'b0;
		buf_wr_en   <= 1'b0;
		buf_wr_addr <= '0;
		buf_wr_char <= '0;
		lcd_sdo     <= 1'b0;
		test_reset();
		test_init();
		test_busy_polling();
		test_update();
		test_ignored_and_rewrite();
		$display("tb_txtlcd: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb_txtlcd_sva.sv ====
// assertions on the serial bus pins and the byte handshake
// bound into every serial_byte_master instance

`timescale 1ns/1ns
`default_nettype none

module serial_bus_checks (
	input logic       in_clk,
	input logic       in_rst,
	input logic       lcd_cs_n,
	input logic       lcd_sclk,
	input logic       tx_valid,
	input logic [7:0] tx_byte,
	input logic       tx_read_back,
	input logic       tx_taken,
	input logic       idle
);

	// no clock edges while deselected
	a_sclk_low: assert property (@(posedge in_clk) disable iff (in_rst)
		lcd_cs_n |-> !lcd_sclk)
		else $error("lcd_sclk high while lcd_cs_n is high");

	// offered byte held until the master takes it
	a_hold_until_taken: assert property (@(posedge in_clk) disable iff (in_rst)
		tx_valid && !tx_taken |=> tx_valid && $stable(tx_byte) && $stable(tx_read_back))
		else $error("offered byte dropped or changed before tx_taken");

	a_idle_cs: assert property (@(posedge in_clk) disable iff (in_rst)
		!(idle && !lcd_cs_n))
		else $error("idle high while chip select is active");

endmodule

bind serial_byte_master serial_bus_checks i_serial_bus_checks (
	.in_clk(in_clk),
	.in_rst(in_rst),
	.lcd_cs_n(lcd_cs_n),
	.lcd_sclk(lcd_sclk),
	.tx_valid(tx_valid),
	.tx_byte(tx_byte),
	.tx_read_back(tx_read_back),
	.tx_taken(tx_taken),
	.idle(idle)
);

`default_nettype wire

// ==== txtlcd_top.sv ====
// top level of the 4x20 character lcd controller
// sets the clock scaling, the serial clock divider and the wait mode,
// and wires the sequencer to the timer, rom, serial master and buffer

`timescale 1ns/1ns
`default_nettype none

module txtlcd_top import lcd_pkg::*; #(
	parameter int ticks_per_100us = 5000,
	parameter int sclk_div        = 25,
	parameter int use_busy_flag   = 1
) (
	input  logic                     in_clk,
	input  logic                     in_rst,
	input  logic                     update,
	output logic                     update_ready,
	input  logic                     buf_wr_en,
	input  logic [lcd_addr_bits-1:0] buf_wr_addr,
	input  logic [7:0]               buf_wr_char,
	output logic                     lcd_rst_n,
	output logic                     lcd_cs_n,
	output logic                     lcd_sclk,
	output logic                     lcd_sdi,
	input  logic                     lcd_sdo,
	output logic [7:0]               busy_status
);

	// timer
	logic        timer_load, timer_done;
	logic [10:0] timer_units;
	// rom and buffer
	logic [4:0]               rom_index;
	init_cmd_t                rom_entry;
	logic [lcd_addr_bits-1:0] rd_addr;
	logic [7:0]               rd_char;
	// serial master
	logic       tx_valid, tx_read_back, tx_taken, rx_valid, idle;
	logic [7:0] tx_byte, rx_byte;

	lcd_sequencer #(.use_busy_flag(use_busy_flag)) i_lcd_sequencer (
		.in_clk, .in_rst, .update, .update_ready, .busy_status, .lcd_rst_n,
		.timer_load, .timer_units, .timer_done, .rom_index, .rom_entry,
		.rd_addr, .rd_char, .tx_valid, .tx_byte, .tx_read_back, .tx_taken,
		.rx_valid, .rx_byte, .idle
	);

	lcd_wait_timer #(.ticks_per_100us(ticks_per_100us)) i_lcd_wait_timer (
		.in_clk, .in_rst, .timer_load, .timer_units, .timer_done
	);

	lcd_init_rom i_lcd_init_rom (.rom_index, .rom_entry);

	serial_byte_master #(.sclk_div(sclk_div)) i_serial_byte_master (
		.in_clk, .in_rst, .tx_valid, .tx_byte, .tx_read_back, .tx_taken,
		.rx_valid, .rx_byte, .idle, .lcd_cs_n, .lcd_sclk, .lcd_sdi, .lcd_sdo
	);

	text_buffer i_text_buffer (
		.in_clk, .buf_wr_en, .buf_wr_addr, .buf_wr_char, .rd_addr, .rd_char
	);

endmodule

`default_nettype wire

// ==== text_buffer.sv ====
// character memory of the display, one byte per position
// host writes on one port, the sequencer reads on the other
// with one cycle of read latency

`timescale 1ns/1ns
`default_nettype none

module text_buffer import lcd_pkg::*; (
	input  logic                     in_clk,
	input  logic                     buf_wr_en,
	input  logic [lcd_addr_bits-1:0] buf_wr_addr,
	input  logic [7:0]               buf_wr_char,
	input  logic [lcd_addr_bits-1:0] rd_addr,
	output logic [7:0]               rd_char
);

	logic [7:0] mem [lcd_size];

	// host write port
	always_ff @(posedge in_clk) begin
		if (buf_wr_en)
			mem[buf_wr_addr] <= buf_wr_char;
	end

	// registered read port
	always_ff @(posedge in_clk) begin
		rd_char <= mem[rd_addr];
	end

endmodule

`default_nettype wire

// ==== serial_byte_master.sv ====
// serial bus master, one byte per transfer
// msb first, data changes on falling sclk, lcd_sdo is sampled on rising
// sclk; a holding register takes the next byte while the current one
// shifts, and it moves into the shifter at the last falling edge

`timescale 1ns/1ns
`default_nettype none

module serial_byte_master #(
	parameter int sclk_div = 25
) (
	input  logic       in_clk,
	input  logic       in_rst,
	input  logic       tx_valid,
	input  logic [7:0] tx_byte,
	input  logic       tx_read_back,
	output logic       tx_taken,
	output logic       rx_valid,
	output logic [7:0] rx_byte,
	output logic       idle,
	output logic       lcd_cs_n,
	output logic       lcd_sclk,
	output logic       lcd_sdi,
	input  logic       lcd_sdo
);

	localparam int div_w = (sclk_div > 1) ? $clog2(sclk_div) : 1;

	logic             busy, held, chain, sclk_r, cs_n_r;
	logic [div_w-1:0] div_cnt;
	logic [3:0]       bit_cnt;
	logic [7:0]       hold_byte, sh_out, sh_in;
	logic             hold_rd, sh_rd;
	logic             div_end, start, rise, fall, last_fall, finish;

	// half-period strobes
	assign div_end   = busy && (div_cnt == div_w'(sclk_div - 1));
	assign start     = !busy && held;
	assign rise      = div_end && !sclk_r && (bit_cnt != 4'd8 || chain);
	assign fall      = div_end && sclk_r;
	assign last_fall = fall && (bit_cnt == 4'd7);
	assign finish    = div_end && !sclk_r && (bit_cnt == 4'd8) && !chain;

	assign tx_taken = tx_valid && !held;
	assign idle     = !busy && !held;
	assign lcd_cs_n = cs_n_r;
	assign lcd_sclk = sclk_r;
	assign lcd_sdi  = sh_out[7];

	always_ff @(posedge in_clk) begin
		if (in_rst) begin
			busy     <= 1'b0;
			held     <= 1'b0;
			chain    <= 1'b0;
			cs_n_r   <= 1'b1;
			sclk_r   <= 1'b0;
			div_cnt  <= '0;
			bit_cnt  <= '0;
			rx_valid <= 1'b0;
		end else begin
			// all 8 samples are in by the last falling edge
			rx_valid <= last_fall && sh_rd;
			if (tx_taken)
				held <= 1'b1;
			else if (start || (last_fall && held))
				held <= 1'b0;
			if (busy)
				div_cnt <= div_end ? '0 : div_cnt + 1'b1;
			// setup cycle with cs low before the first rising edge
			if (start) begin
				busy    <= 1'b1;
				cs_n_r  <= 1'b0;
				div_cnt <= div_w'(sclk_div - 1);
				bit_cnt <= '0;
			end else if (finish) begin
				busy   <= 1'b0;
				cs_n_r <= 1'b1;
			end
			if (rise) begin
				sclk_r <= 1'b1;
				// first edge of a chained byte
				if (bit_cnt == 4'd8) begin
					bit_cnt <= '0;
					chain   <= 1'b0;
				end
			end
			if (fall) begin
				sclk_r  <= 1'b0;
				bit_cnt <= bit_cnt + 4'd1;
			end
			if (last_fall)
				chain <= held;
		end
	end

	// shift registers and the holding register
	always_ff @(posedge in_clk) begin
		if (tx_taken) begin
			hold_byte <= tx_byte;
			hold_rd   <= tx_read_back;
		end
		if (start || (last_fall && held)) begin
			sh_out <= hold_byte;
			sh_rd  <= hold_rd;
		end else if (fall) begin
			sh_out <= {sh_out[6:0], 1'b0};
		end
		if (rise)
			sh_in <= {sh_in[6:0], lcd_sdo};
		if (last_fall)
			rx_byte <= sh_in;
	end

endmodule

`default_nettype wire

// ==== lcd_sequencer.sv ====
// main controller FSM of the lcd
// reset phases, init table, wait after each command (busy polling or
// fixed delay), then ready; an update sends return home, the data
// control byte and two nibble bytes per buffer character

`timescale 1ns/1ns
`default_nettype none

module lcd_sequencer import lcd_pkg::*; #(
	parameter int use_busy_flag = 1
) (
	input  logic                     in_clk,
	input  logic                     in_rst,
	input  logic                     update,
	output logic                     update_ready,
	output logic [7:0]               busy_status,
	output logic                     lcd_rst_n,
	output logic                     timer_load,
	output logic [10:0]              timer_units,
	input  logic                     timer_done,
	output logic [4:0]               rom_index,
	input  init_cmd_t                rom_entry,
	output logic [lcd_addr_bits-1:0] rd_addr,
	input  logic [7:0]               rd_char,
	output logic                     tx_valid,
	output logic [7:0]               tx_byte,
	output logic                     tx_read_back,
	input  logic                     tx_taken,
	input  logic                     rx_valid,
	input  logic [7:0]               rx_byte,
	input  logic                     idle
);

	// state codes
	localparam logic [3:0] s_start = 4'd0, s_prereset = 4'd1, s_rst_pulse = 4'd2;
	localparam logic [3:0] s_settle = 4'd3, s_cmd = 4'd4, s_poll_cmd = 4'd5;
	localparam logic [3:0] s_poll_rd = 4'd6, s_poll_chk = 4'd7, s_drain = 4'd8;
	localparam logic [3:0] s_timer = 4'd9, s_upd_wait = 4'd10, s_ready = 4'd11;
	localparam logic [3:0] s_home = 4'd12, s_data_ctrl = 4'd13, s_data = 4'd14;
	localparam logic [3:0] s_fetch = 4'd15;

	localparam init_cmd_t home_cmd = '{ctrl_command, 8'h02};

	logic [3:0]               state, nstate;
	logic [4:0]               cmd_idx, n_cmd_idx;
	logic [1:0]               byte_idx, n_byte_idx;
	logic [lcd_addr_bits-1:0] char_idx, n_char_idx;
	logic                     ret_upd, n_ret_upd;
	logic [7:0]               n_busy_status;
	init_cmd_t                cur_cmd;
	lcd_serial_byte_u         tx_word;

	assign lcd_rst_n    = (state != s_rst_pulse);
	assign update_ready = (state == s_ready);
	assign rom_index    = cmd_idx;
	assign rd_addr      = char_idx;
	assign tx_byte      = tx_word;
	assign cur_cmd      = (state == s_home) ? home_cmd : rom_entry;

	always_ff @(posedge in_clk) begin
		if (in_rst) begin
			state       <= s_start;
			cmd_idx     <= '0;
			byte_idx    <= '0;
			char_idx    <= '0;
			ret_upd     <= 1'b0;
			busy_status <= 8'hFF;
		end else begin
			state       <= nstate;
			cmd_idx     <= n_cmd_idx;
			byte_idx    <= n_byte_idx;
			char_idx    <= n_char_idx;
			ret_upd     <= n_ret_upd;
			busy_status <= n_busy_status;
		end
	end

	always_comb begin
		nstate        = state;
		n_cmd_idx     = cmd_idx;
		n_byte_idx    = byte_idx;
		n_char_idx    = char_idx;
		n_ret_upd     = ret_upd;
		n_busy_status = busy_status;
		timer_load    = 1'b0;
		timer_units   = '0;
		tx_valid      = 1'b0;
		tx_read_back  = 1'b0;
		tx_word       = '0;

		case (state)
			// ----------------------------------------------------------------
			// reset phases, each next delay loads on the done cycle
			// ----------------------------------------------------------------
			s_start: begin
				timer_load  = 1'b1;
				timer_units = 11'(delay_prereset);
				nstate      = s_prereset;
			end
			s_prereset: if (timer_done) begin
				timer_load    = 1'b1;
				timer_units   = 11'(delay_reset);
				n_busy_status = 8'hFF;
				nstate        = s_rst_pulse;
			end
			s_rst_pulse: if (timer_done) begin
				timer_load  = 1'b1;
				timer_units = 11'(delay_settle);
				nstate      = s_settle;
			end
			s_settle: if (timer_done)
				nstate = s_cmd;

			// ----------------------------------------------------------------
			// three-byte commands, init table or return home
			// ----------------------------------------------------------------
			s_cmd, s_home: begin
				if (state == s_cmd && cmd_idx == 5'(init_num_commands)) begin
					timer_load  = 1'b1;
					timer_units = 11'(delay_update);
					nstate      = s_upd_wait;
				end else begin
					tx_valid = 1'b1;
					if (byte_idx == 2'd0) begin
						tx_word.ctrl_view.code = cur_cmd.ctrl;
						tx_word.ctrl_view.ones = 4'hF;
					end else if (byte_idx == 2'd1) begin
						tx_word.data_view.nibble = cur_cmd.cmd[3:0];
					end else begin
						tx_word.data_view.nibble = cur_cmd.cmd[7:4];
					end
					if (tx_taken) begin
						n_byte_idx = byte_idx + 2'd1;
						if (byte_idx == 2'd2) begin
							n_byte_idx = '0;
							n_ret_upd  = (state == s_home);
							if (state == s_cmd)
								n_cmd_idx = cmd_idx + 5'd1;
							// polling only applies to init commands
							if (state == s_cmd && use_busy_flag != 0)
								nstate = s_poll_cmd;
							else
								nstate = s_drain;
						end
					end
				end
			end

			// busy poll: read request, then dummy byte clocking the status in
			s_poll_cmd: begin
				tx_valid               = 1'b1;
				tx_word.ctrl_view.code = ctrl_read;
				tx_word.ctrl_view.ones = 4'hF;
				if (tx_taken)
					nstate = s_poll_rd;
			end
			s_poll_rd: begin
				tx_valid     = 1'b1;
				tx_read_back = 1'b1;
				if (tx_taken)
					nstate = s_poll_chk;
			end
			s_poll_chk: if (rx_valid) begin
				n_busy_status = rx_byte;
				nstate        = rx_byte[busy_bit] ? s_poll_cmd : s_cmd;
			end

			// fixed wait starts once the last byte has left the bus
			s_drain: if (idle) begin
				timer_load  = 1'b1;
				timer_units = 11'(delay_cmd);
				nstate      = s_timer;
			end
			s_timer: if (timer_done)
				nstate = ret_upd ? s_data_ctrl : s_cmd;

			// ----------------------------------------------------------------
			// ready and display update
			// ----------------------------------------------------------------
			s_upd_wait: if (timer_done)
				nstate = s_ready;
			s_ready: if (update) begin
				n_char_idx = '0;
				n_byte_idx = '0;
				nstate     = s_home;
			end
			s_data_ctrl: begin
				// rd_addr sits at 0 here, so rd_char is valid in s_data
				tx_valid               = 1'b1;
				tx_word.ctrl_view.code = ctrl_data;
				tx_word.ctrl_view.ones = 4'hF;
				if (tx_taken)
					nstate = s_data;
			end
			s_data: begin
				tx_valid = 1'b1;
				tx_word.data_view.nibble = byte_idx[0] ? rd_char[7:4] : rd_char[3:0];
				if (tx_taken) begin
					n_byte_idx = {1'b0, ~byte_idx[0]};
					if (byte_idx[0]) begin
						if (char_idx == lcd_addr_bits'(lcd_size - 1)) begin
							timer_load  = 1'b1;
							timer_units = 11'(delay_update);
							nstate      = s_upd_wait;
						end else begin
							n_char_idx = char_idx + 1'b1;
							nstate     = s_fetch;
						end
					end
				end
			end
			// one cycle for the registered buffer read
			s_fetch: nstate = s_data;
			default: nstate = s_start;
		endcase
	end

endmodule

`default_nettype wire

// ==== lcd_wait_timer.sv ====
// delay timer in 100 us units
// a load arms it, a prescaler makes the 100 us ticks and the unit count
// runs down; timer_done is high in the last counted cycle only

`timescale 1ns/1ns
`default_nettype none

module lcd_wait_timer #(
	parameter int ticks_per_100us = 5000
) (
	input  logic        in_clk,
	input  logic        in_rst,
	input  logic        timer_load,
	input  logic [10:0] timer_units,
	output logic        timer_done
);

	localparam int presc_w = (ticks_per_100us > 1) ? $clog2(ticks_per_100us) : 1;

	logic               running;
	logic [presc_w-1:0] presc;
	logic [10:0]        units;
	logic               tick;

	// end of one 100 us unit
	assign tick       = (presc == presc_w'(ticks_per_100us - 1));
	assign timer_done = running && tick && (units == 11'd1);

	always_ff @(posedge in_clk) begin
		if (in_rst) begin
			running <= 1'b0;
			presc   <= '0;
			units   <= '0;
		end else if (timer_load) begin
			// a zero load leaves the timer idle
			running <= (timer_units != 11'd0);
			presc   <= '0;
			units   <= timer_units;
		end else if (running) begin
			if (tick) begin
				presc <= '0;
				units <= units - 11'd1;
				if (units == 11'd1)
					running <= 1'b0;
			end else begin
				presc <= presc + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== lcd_init_rom.sv ====
// initialisation table of the display controller
// combinational lookup, the sequencer walks rom_index from 0 to 21
// and sends each entry as control byte, low nibble, high nibble

`timescale 1ns/1ns
`default_nettype none

module lcd_init_rom import lcd_pkg::*; (
	input  logic [4:0] rom_index,
	output init_cmd_t  rom_entry
);

	always_comb begin
		case (rom_index)
			// extended set, re=1 is=1
			5'd0:  rom_entry = '{ctrl_command, 8'h3B};
			// no sleep
			5'd1:  rom_entry = '{ctrl_command, 8'h02};
			// mirrored shift direction
			5'd2:  rom_entry = '{ctrl_command, 8'h06};
			// short font, 4 lines
			5'd3:  rom_entry = '{ctrl_command, 8'h09};
			// scroll off for all lines
			5'd4:  rom_entry = '{ctrl_command, 8'h10};
			5'd5:  rom_entry = '{ctrl_command, 8'hC0};
			// rom select, then rom a as data
			5'd6:  rom_entry = '{ctrl_command, 8'h72};
			5'd7:  rom_entry = '{ctrl_data,    8'h00};
			// temperature control, then its value
			5'd8:  rom_entry = '{ctrl_command, 8'h76};
			5'd9:  rom_entry = '{ctrl_data,    8'h02};
			// re=1 is=0
			5'd10: rom_entry = '{ctrl_command, 8'h3A};
			// double height off, bias bit 1
			5'd11: rom_entry = '{ctrl_command, 8'h12};
			// re=0 is=1
			5'd12: rom_entry = '{ctrl_command, 8'h39};
			// bias bit 0 and oscillator
			5'd13: rom_entry = '{ctrl_command, 8'h1B};
			// regulator on, contrast high bits
			5'd14: rom_entry = '{ctrl_command, 8'h57};
			// contrast low bits
			5'd15: rom_entry = '{ctrl_command, 8'h70};
			// follower and amplifier ratio
			5'd16: rom_entry = '{ctrl_command, 8'h6E};
			// back to re=0 is=0
			5'd17: rom_entry = '{ctrl_command, 8'h38};
			// cursor moves right
			5'd18: rom_entry = '{ctrl_command, 8'h06};
			// display on, no cursor
			5'd19: rom_entry = '{ctrl_command, 8'h0C};
			// clear, then home
			5'd20: rom_entry = '{ctrl_command, 8'h01};
			5'd21: rom_entry = '{ctrl_command, 8'h02};
			// past the table, harmless home command
			default: rom_entry = '{ctrl_command, 8'h02};
		endcase
	end

endmodule

`default_nettype wire

// ==== lcd_pkg.sv ====
// shared constants and types of the 4x20 character lcd controller
// imported by the rtl blocks and by the testbench display model
// delays are given in units of 100 us and scaled by the timer prescaler

`default_nettype none

package lcd_pkg;

	// display geometry
	localparam int lcd_size      = 80;
	localparam int lcd_addr_bits = 7;

	// control codes, upper nibble of a control byte
	localparam logic [3:0] ctrl_command = 4'b0001;
	localparam logic [3:0] ctrl_data    = 4'b0101;
	localparam logic [3:0] ctrl_read    = 4'b0011;

	// delays in 100 us units
	localparam int delay_prereset = 500;
	localparam int delay_reset    = 5;
	localparam int delay_settle   = 10;
	localparam int delay_cmd      = 1;
	localparam int delay_update   = 1000;

	localparam int init_num_commands = 22;

	// busy flag position in a status byte
	localparam int busy_bit = 7;

	// one init table entry
	typedef struct packed {
		logic [3:0] ctrl;
		logic [7:0] cmd;
	} init_cmd_t;

	// a bus byte is either a control byte or a nibble carrier
	typedef union packed {
		struct packed {
			logic [3:0] code;
			logic [3:0] ones;
		} ctrl_view;
		struct packed {
			logic [3:0] zero;
			logic [3:0] nibble;
		} data_view;
	} lcd_serial_byte_u;

endpackage

`default_nettype wire
